//--- Makefile
TOP := sfr_ctrl_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, fail on a failing log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -f sfr_ctrl.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/sfr_addr_decode.sv
// Purely combinational; bit addresses below 80h and unlisted byte addresses decode to no register
`timescale 1ns/1ps
`include "sfr_ctrl_cfg.svh"

module sfr_addr_decode
  import sfr_pkg::*;
(
  input  sfr_req_t req_i,
  output sfr_dec_t dec_o
);

  logic [`SFR_ADDR_W-1:0] byte_addr;   // Byte named by the request
  logic                   addr_ok;     // Address lies in a decodable space
  sfr_sel_t               sel;
  sfr_byte_t              reg_mask;    // Writable bits of the selected register
  sfr_byte_t              bit_mask;    // One-hot of the bit index

  // -------------------------------------------------------------------------
  // Address view
  // -------------------------------------------------------------------------
  always_comb
  begin
    if (!req_i.byte_b)
    begin
      byte_addr = req_i.addr.byte_addr;
      addr_ok   = 1'b1;
    end
    else
    begin
      // A bit address names the byte at base followed by zeros
      byte_addr = {req_i.addr.bit_addr.base, {`SFR_BIT_IDX_W{1'b0}}};
      addr_ok   = req_i.addr.bit_addr.base[`SFR_ADDR_W-`SFR_BIT_IDX_W-1];
    end
  end

  // -------------------------------------------------------------------------
  // Register select
  // -------------------------------------------------------------------------
  always_comb
  begin
    sel = SEL_NONE;
    if (addr_ok)
    begin
      case (byte_addr)
        `SFR_ACC:  sel = SEL_ACC;
        `SFR_B:    sel = SEL_B;
        `SFR_PSW:  sel = SEL_PSW;
        `SFR_SP:   sel = SEL_SP;
        `SFR_DPL:  sel = SEL_DPL;
        `SFR_DPH:  sel = SEL_DPH;
        `SFR_P0:   sel = SEL_P0;
        `SFR_P1:   sel = SEL_P1;
        `SFR_P0EN: sel = SEL_P0EN;
        `SFR_P1EN: sel = SEL_P1EN;
        default:   sel = SEL_NONE;
      endcase
    end
  end

  assign reg_mask = (sel == SEL_PSW) ? `PSW_WMASK : '1;         // Parity stays read-only
  assign bit_mask = sfr_byte_t'(1) << req_i.addr.bit_addr.idx;

  // -------------------------------------------------------------------------
  // Decoded request
  // -------------------------------------------------------------------------
  always_comb
  begin
    dec_o.sel      = sel;
    dec_o.bit_mode = req_i.byte_b;
    dec_o.bit_idx  = req_i.byte_b ? req_i.addr.bit_addr.idx : '0;
    dec_o.wr_en    = !req_i.wr_b && (sel != SEL_NONE);          // Misses are dropped
    dec_o.rd_en    = !req_i.rd_b && req_i.wr_b;                 // Write wins over read
    if (req_i.byte_b)
    begin
      dec_o.wmask = bit_mask & reg_mask;
      dec_o.wdata = {`SFR_DATA_W{req_i.wdata[0]}};             // Bit value on every lane
    end
    else
    begin
      dec_o.wmask = reg_mask;
      dec_o.wdata = req_i.wdata;
    end
  end

endmodule

//--- logic/sfr_core_regs.sv
// PSW flags follow the ALU every cycle unless the core writes PSW; parity lags ACC by one cycle
`timescale 1ns/1ps
`include "sfr_ctrl_cfg.svh"

module sfr_core_regs
  import sfr_pkg::*;
(
  input  logic       reg_ctrl_clk_i,
  input  logic       reg_ctrl_reset_b_i,
  input  sfr_dec_t   dec_i,
  input  alu_flags_t alu_flags_i,
  output sfr_core_t  core_o,
  output alu_flags_t alu_flags_o
);

  sfr_core_t core_q;
  sfr_core_t core_d;

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------
  always_comb
  begin
    core_d = core_q;

    // Hardware updates to PSW
    core_d.psw[`PSW_CY_BIT] = alu_flags_i.cy;
    core_d.psw[`PSW_AC_BIT] = alu_flags_i.ac;
    core_d.psw[`PSW_OV_BIT] = alu_flags_i.ov;
    core_d.psw[`PSW_P_BIT]  = ^core_q.acc;                      // Even parity of current ACC

    // Core writes land on top, so a PSW write overrides the ALU
    if (dec_i.wr_en)
    begin
      case (dec_i.sel)
        SEL_ACC:
        begin
          core_d.acc = sfr_merge(core_q.acc, dec_i.wdata, dec_i.wmask);
        end
        SEL_B:
        begin
          core_d.b = sfr_merge(core_q.b, dec_i.wdata, dec_i.wmask);
        end
        SEL_PSW:
        begin
          core_d.psw = sfr_merge(core_d.psw, dec_i.wdata, dec_i.wmask);
        end
        SEL_SP:
        begin
          core_d.sp = sfr_merge(core_q.sp, dec_i.wdata, dec_i.wmask);
        end
        SEL_DPL:
        begin
          core_d.dpl = sfr_merge(core_q.dpl, dec_i.wdata, dec_i.wmask);
        end
        SEL_DPH:
        begin
          core_d.dph = sfr_merge(core_q.dph, dec_i.wdata, dec_i.wmask);
        end
        default: ;                                              // Port registers live elsewhere
      endcase
    end
  end

  // -------------------------------------------------------------------------
  // Registers
  // -------------------------------------------------------------------------
  always_ff @(posedge reg_ctrl_clk_i)
  begin
    if (!reg_ctrl_reset_b_i)
    begin
      core_q <= '{acc: '0, b: '0, psw: '0, sp: `SP_RESET, dpl: '0, dph: '0};
    end
    else
    begin
      core_q <= core_d;
    end
  end

  assign core_o = core_q;

  // Flags back to the ALU come from the stored PSW
  assign alu_flags_o.cy = core_q.psw[`PSW_CY_BIT];
  assign alu_flags_o.ac = core_q.psw[`PSW_AC_BIT];
  assign alu_flags_o.ov = core_q.psw[`PSW_OV_BIT];

endmodule

//--- logic/sfr_ctrl_cfg.svh
// Sizes and the SFR map are fixed for a two-port core; widening a port needs matching RTL edits
`ifndef SFR_CTRL_CFG_SVH
`define SFR_CTRL_CFG_SVH

// -------------------------------------------------------------------------
// Widths
// -------------------------------------------------------------------------
`define SFR_DATA_W      8            // Core data byte
`define SFR_ADDR_W      8            // Logical SFR address
`define SFR_BIT_IDX_W   3            // Bit index inside a byte
`define SFR_NUM_PORTS   2            // P0 and P1

// -------------------------------------------------------------------------
// Logical SFR addresses
// -------------------------------------------------------------------------
`define SFR_P0          8'h80
`define SFR_SP          8'h81
`define SFR_DPL         8'h82
`define SFR_DPH         8'h83
`define SFR_P0EN        8'h86
`define SFR_P1          8'h90
`define SFR_P1EN        8'h96
`define SFR_PSW         8'hD0
`define SFR_ACC         8'hE0
`define SFR_B           8'hF0

// -------------------------------------------------------------------------
// Reset values and write masks
// -------------------------------------------------------------------------
`define SP_RESET        8'h07        // Stack starts above register bank 0

// Parity is owned by the hardware, the core cannot write it
`define PSW_WMASK       8'hFE

// -------------------------------------------------------------------------
// PSW bit positions
// -------------------------------------------------------------------------
`define PSW_CY_BIT      7            // Carry
`define PSW_AC_BIT      6            // Auxiliary carry
`define PSW_OV_BIT      2            // Overflow
`define PSW_P_BIT       0            // Even parity of ACC

`endif

//--- logic/sfr_ctrl_top.sv
// One clock domain; a request is taken in every cycle its strobe is low, with no back-pressure
`timescale 1ns/1ps
`include "sfr_ctrl_cfg.svh"

module sfr_ctrl_top
  import sfr_pkg::*;
(
  input  logic                               reg_ctrl_clk_i,
  input  logic                               reg_ctrl_reset_b_i,
  input  sfr_req_t                           cpu_req_i,
  input  alu_flags_t                         alu_flags_i,
  input  sfr_byte_t   [`SFR_NUM_PORTS-1:0]   pin_i,
  output sfr_byte_t                          rdata_o,
  output alu_flags_t                         alu_flags_o,
  output port_pad_t   [`SFR_NUM_PORTS-1:0]   pad_o
);

  sfr_dec_t                         dec;          // Decoded core request
  sfr_core_t                        core_state;
  port_state_t [`SFR_NUM_PORTS-1:0] port_state;

  // -------------------------------------------------------------------------
  // Request decode
  // -------------------------------------------------------------------------
  sfr_addr_decode u_decode (
    .req_i (cpu_req_i),
    .dec_o (dec)
  );

  // -------------------------------------------------------------------------
  // Register storage
  // -------------------------------------------------------------------------
  sfr_core_regs u_core_regs (
    .reg_ctrl_clk_i     (reg_ctrl_clk_i),
    .reg_ctrl_reset_b_i (reg_ctrl_reset_b_i),
    .dec_i              (dec),
    .alu_flags_i        (alu_flags_i),
    .core_o             (core_state),
    .alu_flags_o        (alu_flags_o)
  );

  sfr_port_bank u_port_bank (
    .reg_ctrl_clk_i     (reg_ctrl_clk_i),
    .reg_ctrl_reset_b_i (reg_ctrl_reset_b_i),
    .dec_i              (dec),
    .pin_i              (pin_i),
    .port_o             (port_state),
    .pad_o              (pad_o)
  );

  // -------------------------------------------------------------------------
  // Read path
  // -------------------------------------------------------------------------
  sfr_read_mux u_read_mux (
    .reg_ctrl_clk_i     (reg_ctrl_clk_i),
    .reg_ctrl_reset_b_i (reg_ctrl_reset_b_i),
    .dec_i              (dec),
    .core_i             (core_state),
    .port_i             (port_state),
    .rdata_o            (rdata_o)
  );

endmodule

//--- logic/sfr_pkg.sv
// Types shared by the SFR controller blocks; field order of each struct is part of the bus layout
`include "sfr_ctrl_cfg.svh"

package sfr_pkg;

  typedef logic [`SFR_DATA_W-1:0] sfr_byte_t;

  // One address word, read either as a byte address or as a bit address
  typedef union packed {
    logic [`SFR_ADDR_W-1:0] byte_addr;               // Byte view
    struct packed {
      logic [`SFR_ADDR_W-`SFR_BIT_IDX_W-1:0] base;   // Byte base, top bit set for SFR space
      logic [`SFR_BIT_IDX_W-1:0]             idx;    // Bit inside that byte
    } bit_addr;
  } sfr_addr_u;

  // Request from the core, strobes active low
  typedef struct packed {
    logic      wr_b;
    logic      rd_b;
    logic      byte_b;                               // Low for byte access, high for bit access
    sfr_addr_u addr;
    sfr_byte_t wdata;
  } sfr_req_t;

  typedef enum logic [3:0] {
    SEL_NONE,
    SEL_ACC,
    SEL_B,
    SEL_PSW,
    SEL_SP,
    SEL_DPL,
    SEL_DPH,
    SEL_P0,
    SEL_P1,
    SEL_P0EN,
    SEL_P1EN
  } sfr_sel_t;

  // Decoded request as seen by the register blocks
  typedef struct packed {
    sfr_sel_t                  sel;
    logic                      bit_mode;
    logic [`SFR_BIT_IDX_W-1:0] bit_idx;
    logic                      wr_en;
    logic                      rd_en;
    sfr_byte_t                 wmask;                // Bits the write may change
    sfr_byte_t                 wdata;
  } sfr_dec_t;

  typedef struct packed {
    logic cy;
    logic ac;
    logic ov;
  } alu_flags_t;

  typedef struct packed {
    sfr_byte_t out;
    sfr_byte_t oe;
  } port_pad_t;

  typedef struct packed {
    sfr_byte_t acc;
    sfr_byte_t b;
    sfr_byte_t psw;
    sfr_byte_t sp;
    sfr_byte_t dpl;
    sfr_byte_t dph;
  } sfr_core_t;

  typedef struct packed {
    sfr_byte_t latch;
    sfr_byte_t en;
  } port_state_t;

  // Masked bits come from the new value, the rest keep the old one
  function automatic sfr_byte_t sfr_merge(input sfr_byte_t old_val,
                                          input sfr_byte_t new_val,
                                          input sfr_byte_t mask);
    return (old_val & ~mask) | (new_val & mask);
  endfunction

endpackage

//--- logic/sfr_port_bank.sv
// Pins on pin_i are taken as already synchronized; port n uses selects P<n> and P<n>EN in order
`timescale 1ns/1ps
`include "sfr_ctrl_cfg.svh"

module sfr_port_bank
  import sfr_pkg::*;
(
  input  logic                                   reg_ctrl_clk_i,
  input  logic                                   reg_ctrl_reset_b_i,
  input  sfr_dec_t                               dec_i,
  input  sfr_byte_t   [`SFR_NUM_PORTS-1:0]       pin_i,
  output port_state_t [`SFR_NUM_PORTS-1:0]       port_o,
  output port_pad_t   [`SFR_NUM_PORTS-1:0]       pad_o
);

  port_state_t [`SFR_NUM_PORTS-1:0] port_q;
  port_state_t [`SFR_NUM_PORTS-1:0] port_d;

  for (genvar p = 0; p < `SFR_NUM_PORTS; p++)
  begin : g_port
    sfr_sel_t  latch_sel;              // Select of this port's latch
    sfr_sel_t  en_sel;                 // Select of this port's enable
    sfr_byte_t sampled;                // Latch after pin sampling

    assign latch_sel = sfr_sel_t'(SEL_P0 + p);
    assign en_sel    = sfr_sel_t'(SEL_P0EN + p);

    // -----------------------------------------------------------------------
    // Next state
    // -----------------------------------------------------------------------
    // Input bits follow the pin, output bits hold
    assign sampled = (pin_i[p] & ~port_q[p].en) | (port_q[p].latch & port_q[p].en);

    always_comb
    begin
      port_d[p] = port_q[p];
      port_d[p].latch = sampled;
      if (dec_i.wr_en && (dec_i.sel == latch_sel))
      begin
        // Only bits driven out may be written by the core
        port_d[p].latch = sfr_merge(sampled, dec_i.wdata, dec_i.wmask & port_q[p].en);
      end
      if (dec_i.wr_en && (dec_i.sel == en_sel))
      begin
        port_d[p].en = sfr_merge(port_q[p].en, dec_i.wdata, dec_i.wmask);
      end
    end

    // -----------------------------------------------------------------------
    // Registers
    // -----------------------------------------------------------------------
    always_ff @(posedge reg_ctrl_clk_i)
    begin
      if (!reg_ctrl_reset_b_i)
      begin
        port_q[p] <= '0;               // All pins start as inputs
      end
      else
      begin
        port_q[p] <= port_d[p];
      end
    end

    assign pad_o[p].out = port_q[p].latch;
    assign pad_o[p].oe  = port_q[p].en;
  end

  assign port_o = port_q;

endmodule

//--- logic/sfr_read_mux.sv
// Read data is registered and held between reads; unmapped selects read as zero
`timescale 1ns/1ps
`include "sfr_ctrl_cfg.svh"

module sfr_read_mux
  import sfr_pkg::*;
(
  input  logic                             reg_ctrl_clk_i,
  input  logic                             reg_ctrl_reset_b_i,
  input  sfr_dec_t                         dec_i,
  input  sfr_core_t                        core_i,
  input  port_state_t [`SFR_NUM_PORTS-1:0] port_i,
  output sfr_byte_t                        rdata_o
);

  sfr_byte_t sel_byte;                 // Byte of the selected register
  sfr_byte_t rd_d;
  sfr_byte_t rdata_q;

  always_comb
  begin
    case (dec_i.sel)
      SEL_ACC:  sel_byte = core_i.acc;
      SEL_B:    sel_byte = core_i.b;
      SEL_PSW:  sel_byte = core_i.psw;
      SEL_SP:   sel_byte = core_i.sp;
      SEL_DPL:  sel_byte = core_i.dpl;
      SEL_DPH:  sel_byte = core_i.dph;
      SEL_P0:   sel_byte = port_i[0].latch;
      SEL_P1:   sel_byte = port_i[1].latch;
      SEL_P0EN: sel_byte = port_i[0].en;
      SEL_P1EN: sel_byte = port_i[1].en;
      default:  sel_byte = '0;
    endcase
  end

  // Bit reads return the addressed bit in bit 0
  assign rd_d = dec_i.bit_mode ? sfr_byte_t'(sel_byte[dec_i.bit_idx]) : sel_byte;

  always_ff @(posedge reg_ctrl_clk_i)
  begin
    if (!reg_ctrl_reset_b_i)
    begin
      rdata_q <= '0;
    end
    else if (dec_i.rd_en)
    begin
      rdata_q <= rd_d;                 // Held until the next read
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- sfr_ctrl.f
+incdir+logic
logic/sfr_pkg.sv
logic/sfr_addr_decode.sv
logic/sfr_core_regs.sv
logic/sfr_port_bank.sv
logic/sfr_read_mux.sv
logic/sfr_ctrl_top.sv
verification/sfr_ctrl_tb.sv

//--- verification/sfr_ctrl_tb.sv
// Self-checking; pins change only between core operations and one request is in flight at a time
`timescale 1ns/1ps
`include "sfr_ctrl_cfg.svh"

module sfr_ctrl_tb
  import sfr_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int TEST_CYCLES = 16 + 24 + 150 + 100 + 80 + 40 + 120;  // Reset, then tests 1 to 6
  localparam sfr_byte_t MAPPED [0:9] = '{`SFR_ACC, `SFR_B, `SFR_PSW, `SFR_SP, `SFR_DPL,
                                         `SFR_DPH, `SFR_P0, `SFR_P1, `SFR_P0EN, `SFR_P1EN};
  localparam sfr_byte_t BIT_REGS [0:4] = '{`SFR_ACC, `SFR_B, `SFR_PSW, `SFR_P0, `SFR_P1};

  logic                             clk;
  logic                             rst_b;
  sfr_req_t                         req;
  alu_flags_t                       alu_in;
  alu_flags_t                       alu_out;
  sfr_byte_t   [`SFR_NUM_PORTS-1:0] pins;
  port_pad_t   [`SFR_NUM_PORTS-1:0] pads;
  sfr_byte_t                        rdata;

  sfr_byte_t  mdl [0:255];             // Expected register image by byte address
  sfr_byte_t  exp_q[$];
  sfr_byte_t  act_q[$];
  string      name_q[$];
  sfr_byte_t  cur_exp;
  sfr_byte_t  cur_act;
  string      cur_name;
  string      test_name;
  sfr_byte_t  data;
  sfr_byte_t  addr;
  logic [2:0] idx;
  int         seed = 32'hb95f5e53;
  int         checks = 0;
  int         errors = 0;
  int         tests = 0;
  int         test_errs = 0;

  sfr_ctrl_top dut (
    .reg_ctrl_clk_i     (clk),
    .reg_ctrl_reset_b_i (rst_b),
    .cpu_req_i          (req),
    .alu_flags_i        (alu_in),
    .pin_i              (pins),
    .rdata_o            (rdata),
    .alu_flags_o        (alu_out),
    .pad_o              (pads)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  function automatic sfr_byte_t rand_byte();
    int r;
    r = $random(seed);
    return r[7:0];
  endfunction

  function automatic logic is_mapped(input sfr_byte_t a);
    foreach (MAPPED[i])
      if (MAPPED[i] == a)
        return 1'b1;
    return 1'b0;
  endfunction

  // Bit writes touch one bit; PSW parity and input port bits never take core data
  function automatic sfr_byte_t ref_write(input sfr_byte_t old_val, input sfr_byte_t a,
                                          input sfr_byte_t d, input logic bit_mode,
                                          input logic [2:0] i, input sfr_byte_t en);
    sfr_byte_t mask;
    sfr_byte_t val;
    mask = bit_mode ? (8'h01 << i) : 8'hFF;
    val  = bit_mode ? {8{d[0]}} : d;
    if (a == `SFR_PSW)
      mask = mask & `PSW_WMASK;
    mask = mask & en;
    return (old_val & ~mask) | (val & mask);
  endfunction

  // Read data as the core sees it, with ALU flags, ACC parity and live input pins folded in
  function automatic sfr_byte_t ref_read(input sfr_byte_t a, input logic bit_mode,
                                         input logic [2:0] i);
    sfr_byte_t val;
    val = is_mapped(a) ? mdl[a] : 8'h00;
    if (a == `SFR_PSW)
    begin
      val[`PSW_CY_BIT] = alu_in.cy;
      val[`PSW_AC_BIT] = alu_in.ac;
      val[`PSW_OV_BIT] = alu_in.ov;
      val[`PSW_P_BIT]  = ^mdl[`SFR_ACC];
    end
    if (a == `SFR_P0)
      val = (mdl[a] & mdl[`SFR_P0EN]) | (pins[0] & ~mdl[`SFR_P0EN]);
    if (a == `SFR_P1)
      val = (mdl[a] & mdl[`SFR_P1EN]) | (pins[1] & ~mdl[`SFR_P1EN]);
    return bit_mode ? {7'b0, val[i]} : val;
  endfunction

  // ---------------------------------------------------------------------------
  // Stimulus tasks
  // ---------------------------------------------------------------------------
  task automatic core_cycle(input logic wr_b, input logic rd_b, input logic bit_mode,
                            input sfr_byte_t a, input sfr_byte_t d);
    @(posedge clk);
    #2;
    req = {wr_b, rd_b, bit_mode, a, d};
    @(posedge clk);
    #2;
    req = {1'b1, 1'b1, 17'h0};         // Back to idle
  endtask

  task automatic queue_check(input string name, input sfr_byte_t expected,
                             input sfr_byte_t actual);
    exp_q.push_back(expected);
    act_q.push_back(actual);
    name_q.push_back({test_name, " ", name});
  endtask

  task automatic write_reg(input sfr_byte_t a, input sfr_byte_t d, input logic bit_mode,
                           input logic [2:0] i);
    sfr_byte_t en;
    en = (a == `SFR_P0) ? mdl[`SFR_P0EN] : (a == `SFR_P1) ? mdl[`SFR_P1EN] : 8'hFF;
    if (a == `SFR_P0EN)
      mdl[`SFR_P0] = ref_read(`SFR_P0, 1'b0, 3'd0);    // Freeze what the latch sampled
    if (a == `SFR_P1EN)
      mdl[`SFR_P1] = ref_read(`SFR_P1, 1'b0, 3'd0);
    if (is_mapped(a))
      mdl[a] = ref_write(mdl[a], a, d, bit_mode, i, en);
    core_cycle(1'b0, 1'b1, bit_mode, bit_mode ? {a[7:3], i} : a, d);
  endtask

  // Read data is valid after the capture edge, which has passed when core_cycle returns
  task automatic read_reg(input sfr_byte_t a, input logic bit_mode, input logic [2:0] i);
    sfr_byte_t expected;
    expected = ref_read(a, bit_mode, i);
    core_cycle(1'b1, 1'b0, bit_mode, bit_mode ? {a[7:3], i} : a, 8'h00);
    queue_check($sformatf("read %h.%0d", a, i), expected, rdata);
  endtask

  task automatic end_test();
    @(negedge clk);
    #1;
    $display("test %-9s %s, %0d errors", test_name, (errors == test_errs) ? "ok" : "failed",
             errors - test_errs);
    tests++;
    test_errs = errors;
  endtask

  // Compares every queued result with its reference value
  always @(negedge clk)
  begin
    while (exp_q.size() > 0)
    begin
      cur_exp  = exp_q.pop_front();
      cur_act  = act_q.pop_front();
      cur_name = name_q.pop_front();
      checks++;
      if (cur_act !== cur_exp)
      begin
        errors++;
        $display("mismatch %s: expected %h, actual %h", cur_name, cur_exp, cur_act);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial
  begin
    req    = {1'b1, 1'b1, 17'h0};
    alu_in = '0;
    pins   = '0;
    rst_b  = 1'b0;
    foreach (mdl[i])
      mdl[i] = 8'h00;
    mdl[`SFR_SP] = `SP_RESET;
    repeat (16) @(posedge clk);
    #2;
    rst_b = 1'b1;

    test_name = "reset";
    foreach (MAPPED[i])
      read_reg(MAPPED[i], 1'b0, 3'd0);
    queue_check("pad oe", 8'h00, pads[0].oe | pads[1].oe);
    end_test();

    test_name = "byte";
    for (int n = 0; n < 4; n++)
    begin
      foreach (MAPPED[i])
      begin
        if (i < 6)                     // ACC to DPH lead the map
        begin
          data = rand_byte();
          if (MAPPED[i] == `SFR_PSW)
            alu_in = {data[`PSW_CY_BIT], data[`PSW_AC_BIT], data[`PSW_OV_BIT]};
          write_reg(MAPPED[i], data, 1'b0, 3'd0);
          read_reg(`SFR_PSW, 1'b1, 3'(`PSW_P_BIT));   // Parity two edges after the write
          read_reg(MAPPED[i], 1'b0, 3'd0);
        end
      end
    end
    end_test();

    test_name = "bit";
    write_reg(`SFR_P0EN, 8'hFF, 1'b0, 3'd0);           // Drive both ports so bit writes land
    write_reg(`SFR_P1EN, 8'hFF, 1'b0, 3'd0);
    repeat (3)
    begin
      foreach (BIT_REGS[i])
      begin
        data = rand_byte();
        idx  = data[6:4];
        write_reg(BIT_REGS[i], data, 1'b1, idx);
        read_reg(BIT_REGS[i], 1'b0, 3'd0);
        read_reg(BIT_REGS[i], 1'b1, idx);
      end
    end
    end_test();

    test_name = "ports";
    for (int n = 0; n < 6; n++)
    begin
      pins[0] = rand_byte();
      pins[1] = rand_byte();
      data    = rand_byte();
      write_reg(`SFR_P0EN, data, 1'b0, 3'd0);
      write_reg(`SFR_P1EN, ~data, 1'b0, 3'd0);
      write_reg(`SFR_P0, rand_byte(), 1'b0, 3'd0);
      write_reg(`SFR_P1, rand_byte(), 1'b0, 3'd0);
      queue_check("pad0 out", ref_read(`SFR_P0, 1'b0, 3'd0), pads[0].out);
      queue_check("pad0 oe", mdl[`SFR_P0EN], pads[0].oe);
      queue_check("pad1 out", ref_read(`SFR_P1, 1'b0, 3'd0), pads[1].out);
      queue_check("pad1 oe", mdl[`SFR_P1EN], pads[1].oe);
      read_reg(`SFR_P0, 1'b0, 3'd0);
      read_reg(`SFR_P1, 1'b0, 3'd0);
    end
    end_test();

    test_name = "alu";
    for (int n = 0; n < 6; n++)
    begin
      data   = rand_byte();
      alu_in = data[2:0];
      read_reg(`SFR_PSW, 1'b0, 3'd0);
      queue_check("flags out", {5'b0, alu_in}, {5'b0, alu_out});
      data   = rand_byte();
      alu_in = ~{data[`PSW_CY_BIT], data[`PSW_AC_BIT], data[`PSW_OV_BIT]};
      write_reg(`SFR_PSW, data, 1'b0, 3'd0);             // Core write beats the ALU
      queue_check("override", {5'b0, data[7], data[6], data[2]}, {5'b0, alu_out});
      read_reg(`SFR_PSW, 1'b0, 3'd0);                    // ALU owns the flags again
    end
    end_test();

    test_name = "unmapped";
    write_reg(`SFR_DPH, 8'hA5, 1'b0, 3'd0);              // Known nonzero byte ahead of each miss
    for (int n = 0; n < 8; n++)
    begin
      do
        addr = rand_byte();
      while (is_mapped(addr));
      data = rand_byte();
      write_reg(addr, data, 1'b0, 3'd0);
      write_reg({1'b0, addr[6:3], 3'b000}, data, 1'b1, data[2:0]);   // Bit space below 80h
      read_reg(`SFR_DPH, 1'b0, 3'd0);
      read_reg(addr, 1'b0, 3'd0);
      read_reg(`SFR_DPH, 1'b0, 3'd0);
      read_reg({1'b0, addr[6:3], 3'b000}, 1'b1, data[2:0]);
    end
    foreach (MAPPED[i])
      read_reg(MAPPED[i], 1'b0, 3'd0);
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // Twice the summed test length
  initial
  begin
    #(TEST_CYCLES * 2 * CLK_PERIOD);
    $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES * 2);
    $display(">>> FAIL");
    $finish;
  end

endmodule
